//--- hw/axil_pkg.sv
`default_nettype none

package axil_pkg;

  // bus widths
  localparam int ADDR_W = 16;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;

  // address map: | window 15:8 | slave 7:6 | word 5:2 | byte 1:0 |
  localparam int N_SLV  = 4;
  localparam int SEL_W  = 2;
  localparam int WORD_W = 4;   // 16 words per slave
  localparam int OFF_L  = 2;
  localparam int SEL_L  = OFF_L + WORD_W;
  localparam int WIN_L  = SEL_L + SEL_W;
  localparam logic [ADDR_W-1:0] ADDR_BASE = 16'hca00;

  localparam int PROB_W = 8;   // one prng byte per random decision

  localparam int FIFO_DEPTH = 4;
  localparam int PTR_W      = $clog2(FIFO_DEPTH);
  localparam int CNT_W      = 3; // must hold FIFO_DEPTH

  localparam int IDLE_TIMEOUT = 3;
  localparam int IDLE_CNT_W   = $clog2(IDLE_TIMEOUT + 1);

  localparam logic [31:0] PRNG_SEED = 32'h2545_f491; // any nonzero value

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01, // never returned, AXI4-lite has no exclusives
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } resp_e;

  typedef enum logic {
    ROUTE_FREE,
    ROUTE_LOCKED
  } route_e;

endpackage

`default_nettype wire

//--- hw/resp_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module resp_fifo #(
  parameter int WIDTH = 2
) (
  input  logic             i_clk,
  input  logic             i_arst_n,
  input  logic             i_push,
  input  logic             i_pop,
  input  logic [WIDTH-1:0] i_data,
  output logic [WIDTH-1:0] o_data,
  output logic             o_empty,
  output logic             o_full
);
  import axil_pkg::*;

  logic [WIDTH-1:0] mem [FIFO_DEPTH];
  logic [PTR_W:0]   wr_ptr; // extra msb tells full from empty
  logic [PTR_W:0]   rd_ptr;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (i_push) wr_ptr <= wr_ptr + 1'b1;
      if (i_pop)  rd_ptr <= rd_ptr + 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_push) mem[wr_ptr[PTR_W-1:0]] <= i_data;
  end

  assign o_data  = mem[rd_ptr[PTR_W-1:0]]; // head, valid when not empty
  assign o_empty = (wr_ptr == rd_ptr);
  assign o_full  = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                   (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);

  ap_no_overrun: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    !(i_push && o_full) && !(i_pop && o_empty));

endmodule

`default_nettype wire

//--- hw/prng_xorshift.sv
`timescale 1ns/1ps
`default_nettype none

module prng_xorshift (
  input  logic        i_clk,
  input  logic        i_arst_n,
  output logic [31:0] o_word
);
  import axil_pkg::*;

  logic [31:0] state;
  logic [31:0] x1;
  logic [31:0] x2;
  logic        seeded;

  // xorshift32, shifts 13/17/5
  assign x1 = state ^ (state << 13);
  assign x2 = x1 ^ (x1 >> 17);

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state  <= '0;
      seeded <= 1'b0;
    end else if (!seeded) begin
      state  <= PRNG_SEED; // first cycle out of reset
      seeded <= 1'b1;
    end else begin
      state <= x2 ^ (x2 << 5);
    end
  end

  assign o_word = state;

  // zero is a fixed point of xorshift, the sequence would die there
  ap_nonzero: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    seeded |-> state != '0);

endmodule

`default_nettype wire

//--- hw/axil_req_router.sv
`timescale 1ns/1ps
`default_nettype none

module axil_req_router (
  input  logic                        i_clk,
  input  logic                        i_arst_n,
  input  logic [axil_pkg::ADDR_W-1:0] i_awaddr,
  input  logic                        i_awvalid,
  input  logic [axil_pkg::DATA_W-1:0] i_wdata,
  input  logic [axil_pkg::STRB_W-1:0] i_wstrb,
  input  logic                        i_wvalid,
  input  logic [axil_pkg::ADDR_W-1:0] i_araddr,
  input  logic                        i_arvalid,
  output logic                        o_awready,
  output logic                        o_wready,
  output logic                        o_arready,
  output logic [axil_pkg::N_SLV-1:0]  o_wr_valid,
  output logic [axil_pkg::N_SLV-1:0]  o_rd_valid,
  input  logic [axil_pkg::N_SLV-1:0]  i_wr_ready,
  input  logic [axil_pkg::N_SLV-1:0]  i_rd_ready,
  input  logic                        i_wr_done,
  input  logic                        i_rd_done,
  output logic [axil_pkg::SEL_W-1:0]  o_wr_sel,
  output logic [axil_pkg::SEL_W-1:0]  o_rd_sel,
  output logic                        o_wr_busy,
  output logic                        o_rd_busy
);
  import axil_pkg::*;

  // index 0 is the write direction, 1 the read direction
  logic [1:0]       req_valid;
  logic [1:0]       can_go;
  logic [1:0]       acc;
  logic [1:0]       done;
  logic [SEL_W-1:0] req_sel  [2];
  logic [SEL_W-1:0] lock_sel [2];
  logic [CNT_W-1:0] cnt      [2];
  logic [N_SLV-1:0] slv_ready[2];
  route_e           state    [2];

  assign req_valid    = {i_arvalid, i_awvalid && i_wvalid}; // aw and w go together
  assign req_sel[0]   = i_awaddr[SEL_L +: SEL_W];
  assign req_sel[1]   = i_araddr[SEL_L +: SEL_W];
  assign slv_ready[0] = i_wr_ready;
  assign slv_ready[1] = i_rd_ready;
  assign done         = {i_rd_done, i_wr_done};

  always_comb begin
    for (int d = 0; d < 2; d++) begin
      // a different slave must wait until the locked one has drained
      can_go[d] = (state[d] == ROUTE_FREE || lock_sel[d] == req_sel[d]) &&
                  (cnt[d] != CNT_W'(FIFO_DEPTH));
      acc[d]    = req_valid[d] && can_go[d] && slv_ready[d][req_sel[d]];
    end
  end

  assign o_wr_valid = (req_valid[0] && can_go[0]) ? N_SLV'(1) << req_sel[0] : '0;
  assign o_rd_valid = (req_valid[1] && can_go[1]) ? N_SLV'(1) << req_sel[1] : '0;
  assign o_awready  = acc[0];
  assign o_wready   = acc[0];
  assign o_arready  = acc[1];

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int d = 0; d < 2; d++) begin
        state[d]    <= ROUTE_FREE;
        lock_sel[d] <= '0;
        cnt[d]      <= '0;
      end
    end else begin
      for (int d = 0; d < 2; d++) begin
        cnt[d] <= cnt[d] + CNT_W'(acc[d]) - CNT_W'(done[d]);
        if (acc[d]) begin
          state[d]    <= ROUTE_LOCKED;
          lock_sel[d] <= req_sel[d];
        end else if (done[d] && cnt[d] == CNT_W'(1)) begin
          state[d] <= ROUTE_FREE; // last response gone
        end
      end
    end
  end

  assign o_wr_sel  = lock_sel[0];
  assign o_rd_sel  = lock_sel[1];
  assign o_wr_busy = (state[0] == ROUTE_LOCKED);
  assign o_rd_busy = (state[1] == ROUTE_LOCKED);

  // a completion at the bus must match a request accepted earlier
  ap_no_underflow: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    !(i_wr_done && cnt[0] == '0) && !(i_rd_done && cnt[1] == '0));

  // master under test must hold its write payload while stalled
  ap_w_stable: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    i_awvalid && i_wvalid && !o_wready |=>
      $stable(i_awaddr) && $stable(i_wdata) && $stable(i_wstrb));

endmodule

`default_nettype wire

//--- hw/axil_random_slave.sv
`timescale 1ns/1ps
`default_nettype none

module axil_random_slave #(
  parameter int SLV_IDX = 0
) (
  input  logic                        i_clk,
  input  logic                        i_arst_n,
  input  logic                        i_wr_valid,
  input  logic [axil_pkg::ADDR_W-1:0] i_awaddr,
  input  logic [axil_pkg::DATA_W-1:0] i_wdata,
  input  logic [axil_pkg::STRB_W-1:0] i_wstrb,
  output logic                        o_wr_ready,
  input  logic                        i_rd_valid,
  input  logic [axil_pkg::ADDR_W-1:0] i_araddr,
  output logic                        o_rd_ready,
  output logic                        o_b_valid,
  output axil_pkg::resp_e             o_b_resp,
  input  logic                        i_b_ready,
  output logic                        o_r_valid,
  output axil_pkg::resp_e             o_r_resp,
  output logic [axil_pkg::DATA_W-1:0] o_r_data,
  input  logic                        i_r_ready,
  input  logic [31:0]                 i_prng_word,
  input  logic [axil_pkg::PROB_W-1:0] i_pr_req_stall,
  input  logic [axil_pkg::PROB_W-1:0] i_pr_resp_stall,
  input  logic [axil_pkg::PROB_W-1:0] i_pr_resp_err,
  input  logic [axil_pkg::PROB_W-1:0] i_pr_corrupt
);
  import axil_pkg::*;

  logic [63:0]       word_x2;
  logic [31:0]       rnd;
  logic              do_req_stall;
  logic              do_resp_stall;
  logic              do_err;
  logic              do_corrupt;
  logic              wr_acc;
  logic              rd_acc;
  logic              mem_we;
  logic              aw_decerr;
  logic              ar_decerr;
  logic [WORD_W-1:0] aw_off;
  logic [WORD_W-1:0] ar_off;
  logic [DATA_W-1:0] mem [2**WORD_W];
  logic [DATA_W-1:0] rdata;
  resp_e             bresp;
  resp_e             rresp;
  logic              b_pop, b_empty, b_full, b_keep;
  logic              r_pop, r_empty, r_full, r_keep;
  logic [1:0]        b_dout;
  logic [DATA_W+1:0] r_dout;

  // each slave sees the shared word rotated by its own byte offset
  assign word_x2 = {i_prng_word, i_prng_word};
  assign rnd     = word_x2[8*(SLV_IDX%4) +: 32];

  assign do_req_stall  = i_pr_req_stall  > rnd[0*PROB_W +: PROB_W];
  assign do_resp_stall = i_pr_resp_stall > rnd[1*PROB_W +: PROB_W];
  assign do_err        = i_pr_resp_err   > rnd[2*PROB_W +: PROB_W];
  assign do_corrupt    = i_pr_corrupt    > rnd[3*PROB_W +: PROB_W];

  assign o_wr_ready = !do_req_stall && !b_full; // room for the response
  assign o_rd_ready = !do_req_stall && !r_full;
  assign wr_acc     = i_wr_valid && o_wr_ready;
  assign rd_acc     = i_rd_valid && o_rd_ready;

  assign aw_off    = i_awaddr[OFF_L +: WORD_W];
  assign ar_off    = i_araddr[OFF_L +: WORD_W];
  assign aw_decerr = (i_awaddr[ADDR_W-1:WIN_L] != ADDR_BASE[ADDR_W-1:WIN_L]);
  assign ar_decerr = (i_araddr[ADDR_W-1:WIN_L] != ADDR_BASE[ADDR_W-1:WIN_L]);
  assign mem_we    = wr_acc && !aw_decerr;

  assign bresp = aw_decerr ? RESP_DECERR : do_err ? RESP_SLVERR : RESP_OKAY;
  assign rresp = ar_decerr ? RESP_DECERR : do_err ? RESP_SLVERR : RESP_OKAY;

  always_ff @(posedge i_clk) begin
    for (int i = 0; i < STRB_W; i++) begin
      if (mem_we && i_wstrb[i])
        mem[aw_off][8*i +: 8] <= i_wdata[8*i +: 8];
    end
  end

  // old contents on a same-cycle write to the same word
  always_comb begin
    rdata = ar_decerr ? '0 : mem[ar_off];
    if (do_corrupt)
      rdata = rdata ^ (DATA_W'(1) << i_prng_word[4:0]); // single bit flip
  end

  resp_fifo #(.WIDTH(2)) u_b_fifo (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_push   (wr_acc),
    .i_pop    (b_pop),
    .i_data   (bresp),
    .o_data   (b_dout),
    .o_empty  (b_empty),
    .o_full   (b_full)
  );

  resp_fifo #(.WIDTH(DATA_W + 2)) u_r_fifo (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_push   (rd_acc),
    .i_pop    (r_pop),
    .i_data   ({rresp, rdata}),
    .o_data   (r_dout),
    .o_empty  (r_empty),
    .o_full   (r_full)
  );

  // once shown, valid stays up until taken
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      b_keep <= 1'b0;
      r_keep <= 1'b0;
    end else begin
      b_keep <= o_b_valid && !i_b_ready;
      r_keep <= o_r_valid && !i_r_ready;
    end
  end

  assign o_b_valid = !b_empty && (!do_resp_stall || b_keep);
  assign o_r_valid = !r_empty && (!do_resp_stall || r_keep);
  assign b_pop     = o_b_valid && i_b_ready;
  assign r_pop     = o_r_valid && i_r_ready;
  assign o_b_resp  = resp_e'(b_dout);
  assign o_r_resp  = resp_e'(r_dout[DATA_W +: 2]);
  assign o_r_data  = r_dout[DATA_W-1:0];

  ap_b_hold: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    o_b_valid && !i_b_ready |=> o_b_valid && $stable(o_b_resp));

  ap_r_hold: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    o_r_valid && !i_r_ready |=> o_r_valid && $stable(o_r_resp) && $stable(o_r_data));

  // an out-of-window write leaves the aliased word untouched
  ap_decerr_no_write: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    wr_acc && aw_decerr |=> mem[$past(aw_off)] === $past(mem[aw_off]));

endmodule

`default_nettype wire

//--- hw/axil_resp_merge.sv
`timescale 1ns/1ps
`default_nettype none

module axil_resp_merge (
  input  logic                                           i_clk,
  input  logic                                           i_arst_n,
  input  logic [axil_pkg::SEL_W-1:0]                     i_wr_sel,
  input  logic [axil_pkg::SEL_W-1:0]                     i_rd_sel,
  input  logic                                           i_wr_busy,
  input  logic                                           i_rd_busy,
  input  logic [axil_pkg::N_SLV-1:0]                     i_b_valid,
  input  axil_pkg::resp_e [axil_pkg::N_SLV-1:0]          i_b_resp,
  input  logic [axil_pkg::N_SLV-1:0]                     i_r_valid,
  input  axil_pkg::resp_e [axil_pkg::N_SLV-1:0]          i_r_resp,
  input  logic [axil_pkg::N_SLV-1:0][axil_pkg::DATA_W-1:0] i_r_data,
  output logic [axil_pkg::N_SLV-1:0]                     o_b_ready,
  output logic [axil_pkg::N_SLV-1:0]                     o_r_ready,
  output logic                                           o_bvalid,
  output axil_pkg::resp_e                                o_bresp,
  output logic                                           o_rvalid,
  output axil_pkg::resp_e                                o_rresp,
  output logic [axil_pkg::DATA_W-1:0]                    o_rdata,
  input  logic                                           i_bready,
  input  logic                                           i_rready,
  output logic                                           o_wr_done,
  output logic                                           o_rd_done,
  output logic                                           o_busy,
  output logic                                           o_idle
);
  import axil_pkg::*;

  logic [IDLE_CNT_W-1:0] idle_cnt;

  // only the locked slave can hold a response
  assign o_bvalid  = i_b_valid[i_wr_sel];
  assign o_bresp   = i_b_resp[i_wr_sel];
  assign o_rvalid  = i_r_valid[i_rd_sel];
  assign o_rresp   = i_r_resp[i_rd_sel];
  assign o_rdata   = i_r_data[i_rd_sel];
  assign o_b_ready = i_bready ? N_SLV'(1) << i_wr_sel : '0;
  assign o_r_ready = i_rready ? N_SLV'(1) << i_rd_sel : '0;

  assign o_wr_done = o_bvalid && i_bready;
  assign o_rd_done = o_rvalid && i_rready;
  assign o_busy    = i_wr_busy || i_rd_busy;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n)
      idle_cnt <= IDLE_CNT_W'(IDLE_TIMEOUT); // not idle straight out of reset
    else if (o_busy)
      idle_cnt <= IDLE_CNT_W'(IDLE_TIMEOUT);
    else if (idle_cnt != '0)
      idle_cnt <= idle_cnt - 1'b1;
  end

  assign o_idle = !o_busy && (idle_cnt == '0);

  // idle must mean no slave is still offering a response
  ap_idle_quiet: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    o_idle |-> (i_b_valid == '0) && (i_r_valid == '0));

endmodule

`default_nettype wire

//--- hw/axil_slave_array.sv
`timescale 1ns/1ps
`default_nettype none

module axil_slave_array (
  input  logic                        i_clk,
  input  logic                        i_arst_n,
  input  logic [axil_pkg::ADDR_W-1:0] i_awaddr,
  input  logic                        i_awvalid,
  output logic                        o_awready,
  input  logic [axil_pkg::DATA_W-1:0] i_wdata,
  input  logic [axil_pkg::STRB_W-1:0] i_wstrb,
  input  logic                        i_wvalid,
  output logic                        o_wready,
  output axil_pkg::resp_e             o_bresp,
  output logic                        o_bvalid,
  input  logic                        i_bready,
  input  logic [axil_pkg::ADDR_W-1:0] i_araddr,
  input  logic                        i_arvalid,
  output logic                        o_arready,
  output logic [axil_pkg::DATA_W-1:0] o_rdata,
  output axil_pkg::resp_e             o_rresp,
  output logic                        o_rvalid,
  input  logic                        i_rready,
  input  logic [axil_pkg::PROB_W-1:0] i_pr_req_stall,
  input  logic [axil_pkg::PROB_W-1:0] i_pr_resp_stall,
  input  logic [axil_pkg::PROB_W-1:0] i_pr_resp_err,
  input  logic [axil_pkg::PROB_W-1:0] i_pr_corrupt,
  output logic                        o_busy,
  output logic                        o_idle
);
  import axil_pkg::*;

  logic [31:0]                   prng_word;
  logic [N_SLV-1:0]              wr_valid, wr_ready, rd_valid, rd_ready;
  logic [N_SLV-1:0]              b_valid, b_ready, r_valid, r_ready;
  resp_e [N_SLV-1:0]             b_resp;
  resp_e [N_SLV-1:0]             r_resp;
  logic [N_SLV-1:0][DATA_W-1:0]  r_data;
  logic [SEL_W-1:0]              wr_sel, rd_sel;
  logic                          wr_busy, rd_busy, wr_done, rd_done;

  prng_xorshift u_prng (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .o_word   (prng_word)
  );

  axil_req_router u_router (
    .i_clk      (i_clk),
    .i_arst_n   (i_arst_n),
    .i_awaddr   (i_awaddr),
    .i_awvalid  (i_awvalid),
    .i_wdata    (i_wdata),
    .i_wstrb    (i_wstrb),
    .i_wvalid   (i_wvalid),
    .i_araddr   (i_araddr),
    .i_arvalid  (i_arvalid),
    .o_awready  (o_awready),
    .o_wready   (o_wready),
    .o_arready  (o_arready),
    .o_wr_valid (wr_valid),
    .o_rd_valid (rd_valid),
    .i_wr_ready (wr_ready),
    .i_rd_ready (rd_ready),
    .i_wr_done  (wr_done),
    .i_rd_done  (rd_done),
    .o_wr_sel   (wr_sel),
    .o_rd_sel   (rd_sel),
    .o_wr_busy  (wr_busy),
    .o_rd_busy  (rd_busy)
  );

  for (genvar k = 0; k < N_SLV; k++) begin : g_slv
    axil_random_slave #(.SLV_IDX(k)) u_slave (
      .i_clk           (i_clk),
      .i_arst_n        (i_arst_n),
      .i_wr_valid      (wr_valid[k]),
      .i_awaddr        (i_awaddr),
      .i_wdata         (i_wdata),
      .i_wstrb         (i_wstrb),
      .o_wr_ready      (wr_ready[k]),
      .i_rd_valid      (rd_valid[k]),
      .i_araddr        (i_araddr),
      .o_rd_ready      (rd_ready[k]),
      .o_b_valid       (b_valid[k]),
      .o_b_resp        (b_resp[k]),
      .i_b_ready       (b_ready[k]),
      .o_r_valid       (r_valid[k]),
      .o_r_resp        (r_resp[k]),
      .o_r_data        (r_data[k]),
      .i_r_ready       (r_ready[k]),
      .i_prng_word     (prng_word),
      .i_pr_req_stall  (i_pr_req_stall),
      .i_pr_resp_stall (i_pr_resp_stall),
      .i_pr_resp_err   (i_pr_resp_err),
      .i_pr_corrupt    (i_pr_corrupt)
    );
  end

  axil_resp_merge u_merge (
    .i_clk     (i_clk),
    .i_arst_n  (i_arst_n),
    .i_wr_sel  (wr_sel),
    .i_rd_sel  (rd_sel),
    .i_wr_busy (wr_busy),
    .i_rd_busy (rd_busy),
    .i_b_valid (b_valid),
    .i_b_resp  (b_resp),
    .i_r_valid (r_valid),
    .i_r_resp  (r_resp),
    .i_r_data  (r_data),
    .o_b_ready (b_ready),
    .o_r_ready (r_ready),
    .o_bvalid  (o_bvalid),
    .o_bresp   (o_bresp),
    .o_rvalid  (o_rvalid),
    .o_rresp   (o_rresp),
    .o_rdata   (o_rdata),
    .i_bready  (i_bready),
    .i_rready  (i_rready),
    .o_wr_done (wr_done),
    .o_rd_done (rd_done),
    .o_busy    (o_busy),
    .o_idle    (o_idle)
  );

endmodule

`default_nettype wire

//--- bench/tb_axil_slave_array.sv
`timescale 1ns/1ps
`default_nettype none

module tb_axil_slave_array;
  import axil_pkg::*;

  localparam int CLK_PERIOD = 40;
  localparam int SETTLE     = CLK_PERIOD / 4; // sample point inside the low phase
  localparam int MAX_CYCLES = 200 * 64;

  logic              clk;
  logic              arst_n;
  logic [ADDR_W-1:0] awaddr;
  logic              awvalid;
  logic              awready;
  logic [DATA_W-1:0] wdata;
  logic [STRB_W-1:0] wstrb;
  logic              wvalid;
  logic              wready;
  resp_e             bresp;
  logic              bvalid;
  logic              bready;
  logic [ADDR_W-1:0] araddr;
  logic              arvalid;
  logic              arready;
  logic [DATA_W-1:0] rdata;
  resp_e             rresp;
  logic              rvalid;
  logic              rready;
  logic [PROB_W-1:0] pr_req_stall;
  logic [PROB_W-1:0] pr_resp_stall;
  logic [PROB_W-1:0] pr_resp_err;
  logic [PROB_W-1:0] pr_corrupt;
  logic              busy;
  logic              idle;

  logic [DATA_W-1:0] ref_mem [64]; // index is {slave select, word offset}
  logic              rand_ready;   // toggle bready/rready at random
  int                cycle_cnt;
  int                err_cnt;
  int                check_cnt;
  int                test_cnt;

  axil_slave_array i_axil_slave_array (
    .i_clk           (clk),
    .i_arst_n        (arst_n),
    .i_awaddr        (awaddr),
    .i_awvalid       (awvalid),
    .o_awready       (awready),
    .i_wdata         (wdata),
    .i_wstrb         (wstrb),
    .i_wvalid        (wvalid),
    .o_wready        (wready),
    .o_bresp         (bresp),
    .o_bvalid        (bvalid),
    .i_bready        (bready),
    .i_araddr        (araddr),
    .i_arvalid       (arvalid),
    .o_arready       (arready),
    .o_rdata         (rdata),
    .o_rresp         (rresp),
    .o_rvalid        (rvalid),
    .i_rready        (rready),
    .i_pr_req_stall  (pr_req_stall),
    .i_pr_resp_stall (pr_resp_stall),
    .i_pr_resp_err   (pr_resp_err),
    .i_pr_corrupt    (pr_corrupt),
    .o_busy          (busy),
    .o_idle          (idle)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("timeout after %0d cycles, a handshake never completed", cycle_cnt);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    check_cnt++;
    assert (got === exp) else begin
      $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    check_cnt++;
    assert (cond) else begin
      $display("Error at %0t ns: %s", $time, what);
      err_cnt++;
    end
  endtask

  task automatic end_test(input string name, input int err_start);
    test_cnt++;
    $display("test %-20s %s, %0d errors", name,
             (err_cnt == err_start) ? "ok" : "failed", err_cnt - err_start);
  endtask

  function automatic logic [ADDR_W-1:0] win_addr(input int idx);
    return {ADDR_BASE[ADDR_W-1:WIN_L], idx[SEL_W+WORD_W-1:0], {OFF_L{1'b0}}};
  endfunction

  // byte lanes with strobe set take the new data
  task automatic model_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                             input logic [STRB_W-1:0] strb);
    if (addr[ADDR_W-1:WIN_L] == ADDR_BASE[ADDR_W-1:WIN_L]) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (strb[b])
          ref_mem[addr[WIN_L-1:OFF_L]][8*b +: 8] = data[8*b +: 8];
      end
    end
  endtask

  task automatic set_probs(input int req_stall, input int resp_stall, input int err,
                           input int corrupt);
    pr_req_stall  = PROB_W'(req_stall);
    pr_resp_stall = PROB_W'(resp_stall);
    pr_resp_err   = PROB_W'(err);
    pr_corrupt    = PROB_W'(corrupt);
  endtask

  // all bus tasks start and end just after a falling edge
  task automatic issue_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                             input logic [STRB_W-1:0] strb);
    logic accepted;
    accepted = 1'b0;
    awaddr   = addr;
    wdata    = data;
    wstrb    = strb;
    awvalid  = 1'b1;
    wvalid   = 1'b1;
    while (!accepted) begin
      #SETTLE;
      accepted = awready && wready;
      @(negedge clk);
    end
    awvalid = 1'b0;
    wvalid  = 1'b0;
  endtask

  task automatic issue_read(input logic [ADDR_W-1:0] addr);
    logic accepted;
    accepted = 1'b0;
    araddr   = addr;
    arvalid  = 1'b1;
    while (!accepted) begin
      #SETTLE;
      accepted = arready;
      @(negedge clk);
    end
    arvalid = 1'b0;
  endtask

  task automatic take_b(output resp_e resp);
    logic got;
    got = 1'b0;
    while (!got) begin
      bready = rand_ready ? 1'($urandom_range(1)) : 1'b1;
      #SETTLE;
      got  = bvalid && bready;
      resp = bresp;
      @(negedge clk);
    end
    bready = 1'b0;
  endtask

  task automatic take_r(output resp_e resp, output logic [DATA_W-1:0] data);
    logic got;
    got = 1'b0;
    while (!got) begin
      rready = rand_ready ? 1'($urandom_range(1)) : 1'b1;
      #SETTLE;
      got  = rvalid && rready;
      resp = rresp;
      data = rdata;
      @(negedge clk);
    end
    rready = 1'b0;
  endtask

  task automatic write_word(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                            input logic [STRB_W-1:0] strb, output resp_e resp);
    issue_write(addr, data, strb);
    take_b(resp);
  endtask

  task automatic read_word(input logic [ADDR_W-1:0] addr, output resp_e resp,
                           output logic [DATA_W-1:0] data);
    issue_read(addr);
    take_r(resp, data);
  endtask

  task automatic test_basic();
    resp_e             resp;
    logic [DATA_W-1:0] data;
    int                err_start;
    err_start  = err_cnt;
    rand_ready = 1'b0;
    set_probs(0, 0, 0, 0);
    for (int i = 0; i < 64; i++) begin // every word of every slave
      data = $urandom;
      write_word(win_addr(i), data, '1, resp);
      model_write(win_addr(i), data, '1);
      check_val("bresp", resp, RESP_OKAY);
    end
    for (int i = 0; i < 64; i++) begin
      read_word(win_addr(i), resp, data);
      check_val("rresp", resp, RESP_OKAY);
      check_val("rdata", data, ref_mem[i]);
    end
    end_test("write and read-back", err_start);
  endtask

  task automatic test_strobe();
    resp_e             resp;
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
    int                idx;
    int                err_start;
    err_start = err_cnt;
    for (int i = 0; i < 12; i++) begin
      idx  = $urandom_range(63);
      data = $urandom;
      strb = STRB_W'($urandom);
      write_word(win_addr(idx), data, strb, resp);
      model_write(win_addr(idx), data, strb);
      check_val("bresp", resp, RESP_OKAY);
      read_word(win_addr(idx), resp, data);
      check_val("rdata", data, ref_mem[idx]);
    end
    end_test("byte strobes", err_start);
  endtask

  task automatic test_decerr();
    resp_e             resp;
    logic [DATA_W-1:0] data;
    logic [ADDR_W-1:0] bad;
    int                idx;
    int                err_start;
    err_start = err_cnt;
    for (int i = 0; i < 6; i++) begin
      idx = $urandom_range(63);
      bad = win_addr(idx);
      bad[ADDR_W-1:WIN_L] = bad[ADDR_W-1:WIN_L] ^ 8'(1 + $urandom_range(254));
      data = $urandom;
      write_word(bad, data, '1, resp);
      model_write(bad, data, '1); // model ignores addresses outside the window
      check_val("bresp", resp, RESP_DECERR);
      read_word(bad, resp, data);
      check_val("rresp", resp, RESP_DECERR);
      read_word(win_addr(idx), resp, data);
      check_val("rresp", resp, RESP_OKAY);
      check_val("rdata", data, ref_mem[idx]);
    end
    end_test("decode error", err_start);
  endtask

  task automatic test_slverr();
    resp_e             resp;
    logic [DATA_W-1:0] data;
    int                idx;
    int                n_err;
    int                err_start;
    err_start = err_cnt;
    n_err     = 0;
    set_probs(0, 0, 200, 0);
    for (int i = 0; i < 50; i++) begin
      idx = $urandom_range(63);
      if (i % 2 == 0) begin
        data = $urandom;
        write_word(win_addr(idx), data, '1, resp);
        model_write(win_addr(idx), data, '1); // memory is written even on SLVERR
      end else begin
        read_word(win_addr(idx), resp, data);
        check_val("rdata", data, ref_mem[idx]);
      end
      check_true(resp == RESP_OKAY || resp == RESP_SLVERR,
                 "response is neither OKAY nor SLVERR");
      if (resp == RESP_SLVERR)
        n_err++;
    end
    check_true(n_err > 0, "no SLVERR seen in 50 transactions");
    end_test("random slave error", err_start);
  endtask

  task automatic test_stress();
    resp_e             resp;
    logic [DATA_W-1:0] data;
    int                idx;
    int                err_start;
    err_start  = err_cnt;
    rand_ready = 1'b1;
    set_probs(80, 80, 0, 60);
    for (int sel = 0; sel < N_SLV; sel++) begin
      for (int w = 0; w < FIFO_DEPTH; w++) begin // fills the slave's B FIFO
        idx  = sel * 16 + w;
        data = $urandom;
        issue_write(win_addr(idx), data, '1);
        model_write(win_addr(idx), data, '1);
      end
      for (int w = 0; w < FIFO_DEPTH; w++) begin
        take_b(resp);
        check_val("bresp", resp, RESP_OKAY);
      end
      for (int w = 0; w < FIFO_DEPTH; w++)
        issue_read(win_addr(sel * 16 + w));
      for (int w = 0; w < FIFO_DEPTH; w++) begin
        idx = sel * 16 + w;
        take_r(resp, data);
        check_val("rresp", resp, RESP_OKAY);
        check_cnt++;
        assert ($countones(data ^ ref_mem[idx]) <= 1) else begin
          $display("Mismatch at %0t ns: rdata is %h, expected %h within one bit",
                   $time, data, ref_mem[idx]);
          err_cnt++;
        end
      end
    end
    rand_ready = 1'b0;
    end_test("stalls and corruption", err_start);
  endtask

  task automatic test_idle();
    resp_e             resp;
    logic [DATA_W-1:0] data;
    int                idx;
    int                err_start;
    err_start = err_cnt;
    set_probs(0, 0, 0, 0);
    for (int dir = 0; dir < 2; dir++) begin
      idx = $urandom_range(63);
      if (dir == 0)
        issue_write(win_addr(idx), ref_mem[idx], '1);
      else
        issue_read(win_addr(idx));
      repeat (3) begin // response left unanswered
        #SETTLE;
        check_val("o_busy", busy, 1);
        check_val("o_idle", idle, 0);
        @(negedge clk);
      end
      if (dir == 0)
        take_b(resp);
      else
        take_r(resp, data);
      check_val("resp", resp, RESP_OKAY);
      for (int i = 0; i <= IDLE_TIMEOUT; i++) begin
        #SETTLE;
        check_val("o_busy", busy, 0);
        check_val("o_idle", idle, i == IDLE_TIMEOUT);
        @(negedge clk);
      end
    end
    end_test("busy and idle", err_start);
  endtask

  initial begin
    void'($urandom(32'h1d21));
    clk        = 1'b0;
    arst_n     = 1'b0;
    awaddr     = '0;
    awvalid    = 1'b0;
    wdata      = '0;
    wstrb      = '0;
    wvalid     = 1'b0;
    bready     = 1'b0;
    araddr     = '0;
    arvalid    = 1'b0;
    rready     = 1'b0;
    rand_ready = 1'b0;
    cycle_cnt  = 0;
    err_cnt    = 0;
    check_cnt  = 0;
    test_cnt   = 0;
    set_probs(0, 0, 0, 0);
    repeat (5) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk); // prng takes its seed here
    test_basic();
    test_strobe();
    test_decerr();
    test_slverr();
    test_stress();
    test_idle();
    $display("%0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
hw/axil_pkg.sv
hw/resp_fifo.sv
hw/prng_xorshift.sv
hw/axil_req_router.sv
hw/axil_random_slave.sv
hw/axil_resp_merge.sv
hw/axil_slave_array.sv
bench/tb_axil_slave_array.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_axil_slave_array -o sim -f tb.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "NO ERRORS"; then
  exit 0
fi
exit 1
